/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sdram_mcb
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* list.f */
+incdir+rtl
rtl/mcb_pkg.sv
rtl/mcb_fifo.sv
rtl/mcb_transfer_tracker.sv
rtl/mcb_scheduler.sv
rtl/mcb_burst_engine.sv
rtl/sdram_mcb_top.sv
verif/tb_clock_gen.sv
verif/tb_burst_memory.sv
verif/sdram_mcb_properties.sv
verif/tb_sdram_mcb.sv

/* rtl/mcb_burst_engine.sv */
`timescale 1ns/1ps
`include "mcb_settings.svh"

module mcb_burst_engine (
    input  logic                        clk_sdram,
    input  logic                        rst_n,
    input  logic                        burst_start,
    input  logic                        burst_is_rd,
    input  mcb_pkg::mcb_addr_u          wr_addr,
    input  mcb_pkg::mcb_addr_u          rd_addr,
    input  logic [`MCB_BURST_W-1:0]     wr_len,
    input  logic [`MCB_BURST_W-1:0]     rd_len,
    input  logic                        mem_wr_ack,
    input  logic                        mem_rd_ack,
    output logic                        mem_wr_req,
    output logic                        mem_rd_req,
    output mcb_pkg::mcb_addr_u          mem_addr,
    output logic [`MCB_BURST_W-1:0]     mem_len,
    output logic                        burst_done
);

    import mcb_pkg::*;

    mcb_addr_u                  addr_r;         // held for the whole burst
    logic [`MCB_BURST_W-1:0]    len_r;
    logic [`MCB_BURST_W-1:0]    beat_cnt;       // acknowledged beats so far
    logic                       busy;
    logic                       is_rd_r;
    logic                       beat;

    assign beat       = busy & (is_rd_r ? mem_rd_ack : mem_wr_ack);
    assign burst_done = busy & (beat_cnt == len_r);   // all beats seen
    assign mem_addr   = addr_r;
    assign mem_len    = len_r;

    always_ff @(posedge clk_sdram) begin
        if (burst_start) begin
            addr_r <= burst_is_rd ? rd_addr : wr_addr;
            len_r  <= burst_is_rd ? rd_len  : wr_len;
        end
    end

    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            is_rd_r    <= 1'b0;
            beat_cnt   <= '0;
            mem_wr_req <= 1'b0;
            mem_rd_req <= 1'b0;
        end else if (burst_start) begin
            busy       <= 1'b1;
            is_rd_r    <= burst_is_rd;
            beat_cnt   <= '0;
            mem_wr_req <= ~burst_is_rd;         // level until first ack
            mem_rd_req <= burst_is_rd;
        end else begin
            if (beat) begin
                beat_cnt   <= beat_cnt + 1'b1;
                mem_wr_req <= 1'b0;
                mem_rd_req <= 1'b0;
            end
            if (burst_done) begin
                busy <= 1'b0;                   // back to waiting for a start
            end
        end
    end

endmodule

/* rtl/mcb_fifo.sv */
`timescale 1ns/1ps
`include "mcb_settings.svh"

module mcb_fifo (
    input  logic                        clk_sdram,
    input  logic                        rst_n,
    input  logic                        push,
    input  logic [`MCB_DATA_W-1:0]      push_data,
    input  logic                        pop,
    output logic [`MCB_DATA_W-1:0]      head,
    output logic [`MCB_FIFO_CNT_W-1:0]  count,
    output logic                        full,
    output logic                        empty
);

    localparam int PTR_W = $clog2(`MCB_FIFO_DEPTH);

    logic [`MCB_DATA_W-1:0] mem [`MCB_FIFO_DEPTH];    // storage, no reset
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic                   push_ok;
    logic                   pop_ok;

    assign full    = (count == `MCB_FIFO_CNT_W'(`MCB_FIFO_DEPTH));
    assign empty   = (count == '0);
    assign push_ok = push & ~full;              // drop push when full
    assign pop_ok  = pop & ~empty;              // drop pop when empty
    assign head    = mem[rd_ptr];               // show-ahead, head valid while !empty

    always_ff @(posedge clk_sdram) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;        // wraps at depth
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

endmodule

/* rtl/mcb_pkg.sv */
`include "mcb_settings.svh"

package mcb_pkg;

    // same 24 bits seen two ways
    typedef union packed {
        logic [`MCB_ADDR_W-1:0] linear;         // flat word address, advanced per burst
        struct packed {
            logic [`MCB_BANK_W-1:0] bank;       // top bits
            logic [`MCB_ROW_W-1:0]  row;
            logic [`MCB_COL_W-1:0]  col;        // distance to row end comes from here
        } field;
    } mcb_addr_u;

endpackage

/* rtl/mcb_scheduler.sv */
`timescale 1ns/1ps
`include "mcb_settings.svh"

module mcb_scheduler (
    input  logic                        clk_sdram,
    input  logic                        rst_n,
    input  logic                        mem_init_done,
    input  logic                        wr_pending,
    input  logic                        rd_pending,
    input  logic [`MCB_BURST_W-1:0]     wr_burst_len,
    input  logic [`MCB_BURST_W-1:0]     rd_burst_len,
    input  logic                        wr_last,
    input  logic                        rd_last,
    input  logic [`MCB_FIFO_CNT_W-1:0]  wr_fifo_cnt,
    input  logic [`MCB_FIFO_CNT_W-1:0]  rd_fifo_cnt,
    input  logic                        burst_done,
    output logic                        burst_start,
    output logic                        burst_is_rd,
    output logic                        wr_stage_done,
    output logic                        rd_stage_done,
    output logic                        wr_done,
    output logic                        rd_done
);

    localparam logic [3:0] IDLE          = 4'd0;
    localparam logic [3:0] PRE_WR        = 4'd1;
    localparam logic [3:0] WRITING       = 4'd2;
    localparam logic [3:0] WR_STAGE_CPLT = 4'd3;
    localparam logic [3:0] WR_DONE       = 4'd4;
    localparam logic [3:0] PRE_RD        = 4'd5;
    localparam logic [3:0] READING       = 4'd6;
    localparam logic [3:0] RD_STAGE_CPLT = 4'd7;
    localparam logic [3:0] RD_DONE       = 4'd8;

    logic [3:0] state;
    logic [3:0] state_next;
    logic       rw_toggle;          // 1 gives read the priority
    logic       wr_data_ok;         // whole burst already in write fifo
    logic       rd_room_ok;         // read fifo can take the whole burst
    logic       pick_wr;

    assign wr_data_ok = (wr_fifo_cnt >= {1'b0, wr_burst_len});
    assign rd_room_ok = (({1'b0, rd_fifo_cnt} + {2'b00, rd_burst_len}) <
                         (`MCB_FIFO_CNT_W+1)'(`MCB_FIFO_DEPTH - 1));

    // write goes first unless toggled and a read is waiting
    assign pick_wr = wr_pending && (!rw_toggle || !rd_pending);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (mem_init_done) begin
                    if (pick_wr) begin
                        if (wr_data_ok) begin
                            state_next = PRE_WR;
                        end
                    end else if (rd_pending) begin
                        if (rd_room_ok) begin
                            state_next = PRE_RD;
                        end
                    end
                end
            end
            PRE_WR:        state_next = WRITING;        // one cycle start
            WRITING: begin
                if (burst_done) begin
                    state_next = WR_STAGE_CPLT;
                end
            end
            WR_STAGE_CPLT: state_next = wr_last ? WR_DONE : IDLE;
            WR_DONE:       state_next = IDLE;
            PRE_RD:        state_next = READING;
            READING: begin
                if (burst_done) begin
                    state_next = RD_STAGE_CPLT;
                end
            end
            RD_STAGE_CPLT: state_next = rd_last ? RD_DONE : IDLE;
            RD_DONE:       state_next = IDLE;
            default:       state_next = IDLE;           // unused codes
        endcase
    end

    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            rw_toggle <= 1'b0;
        end else begin
            state <= state_next;
            if (state == WR_STAGE_CPLT || state == RD_STAGE_CPLT) begin
                rw_toggle <= ~rw_toggle;    // hand priority to the other side
            end
        end
    end

    // moore outputs off the state register
    assign burst_start   = (state == PRE_WR) || (state == PRE_RD);
    assign burst_is_rd   = (state == PRE_RD);
    assign wr_stage_done = (state == WR_STAGE_CPLT);     // tracker advances
    assign rd_stage_done = (state == RD_STAGE_CPLT);
    assign wr_done       = (state == WR_DONE);           // single cycle
    assign rd_done       = (state == RD_DONE);

endmodule

/* rtl/mcb_settings.svh */
`ifndef MCB_SETTINGS_SVH
`define MCB_SETTINGS_SVH

// word widths on user and memory side
`define MCB_DATA_W      16          // one sdram word
`define MCB_ADDR_W      24          // word address, bank/row/col
`define MCB_LEN_W       24          // transfer length in words

// address split
`define MCB_BANK_W      2
`define MCB_ROW_W       13
`define MCB_COL_W       9
`define MCB_ROW_WORDS   512         // words in one sdram row

// burst and fifo sizing
`define MCB_BURST_W     10          // needs to hold a full row, 512
`define MCB_FIFO_DEPTH  1024        // entries per direction
`define MCB_FIFO_CNT_W  11          // 0..1024

`endif

/* rtl/mcb_transfer_tracker.sv */
`timescale 1ns/1ps
`include "mcb_settings.svh"

module mcb_transfer_tracker (
    input  logic                        clk_sdram,
    input  logic                        rst_n,
    input  logic                        load,
    input  mcb_pkg::mcb_addr_u          load_addr,
    input  logic [`MCB_LEN_W-1:0]       load_len,
    input  logic                        stage_done,
    output logic                        pending,
    output mcb_pkg::mcb_addr_u          cur_addr,
    output logic [`MCB_BURST_W-1:0]     burst_len,
    output logic                        last_burst
);

    import mcb_pkg::*;

    logic                       load_d1;        // previous load level
    logic                       load_edge_r;    // registered rising edge
    mcb_addr_u                  addr_stage;     // address sampled with the edge
    logic [`MCB_LEN_W-1:0]      len_stage;
    logic [`MCB_LEN_W-1:0]      remaining;      // words still to move
    logic [`MCB_BURST_W-1:0]    to_row_end;     // 1..512
    logic                       fits_in_row;

    // words left before column 512
    assign to_row_end  = `MCB_BURST_W'(`MCB_ROW_WORDS) - {1'b0, cur_addr.field.col};
    assign fits_in_row = (remaining <= `MCB_LEN_W'(to_row_end));
    assign burst_len   = fits_in_row ? remaining[`MCB_BURST_W-1:0] : to_row_end;
    assign last_burst  = fits_in_row;           // this burst empties the transfer

    // capture address and length alongside the edge
    always_ff @(posedge clk_sdram) begin
        addr_stage <= load_addr;
        len_stage  <= load_len;
    end

    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            load_d1     <= 1'b0;
            load_edge_r <= 1'b0;
        end else begin
            load_d1     <= load;
            load_edge_r <= load & ~load_d1;     // one cycle after the rise
        end
    end

    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            pending   <= 1'b0;
            cur_addr  <= '0;
            remaining <= '0;
        end else begin
            if (load_edge_r && !pending) begin
                pending   <= 1'b1;              // new loads ignored from here on
                cur_addr  <= addr_stage;
                remaining <= len_stage;
            end else if (stage_done) begin
                // step past the burst just finished
                cur_addr.linear <= cur_addr.linear + `MCB_ADDR_W'(burst_len);
                remaining       <= remaining - `MCB_LEN_W'(burst_len);
                if (last_burst) begin
                    pending <= 1'b0;            // count hits zero
                end
            end
        end
    end

endmodule

/* rtl/sdram_mcb_top.sv */
`timescale 1ns/1ps
`include "mcb_settings.svh"

module sdram_mcb_top (
    input  logic                        clk_sdram,
    input  logic                        rst_n,
    // user write side
    input  logic                        wr_load,        // level, edge starts a transfer
    input  mcb_pkg::mcb_addr_u          wr_addr,
    input  logic [`MCB_LEN_W-1:0]       wr_length,      // words, non-zero
    input  logic                        wr_req,
    input  logic [`MCB_DATA_W-1:0]      din,
    output logic                        wr_done,
    output logic                        wr_rdy,
    // user read side
    input  logic                        rd_load,
    input  mcb_pkg::mcb_addr_u          rd_addr,
    input  logic [`MCB_LEN_W-1:0]       rd_length,
    input  logic                        rd_req,
    output logic [`MCB_DATA_W-1:0]      dout,           // head of read fifo
    output logic                        rd_done,
    output logic [`MCB_FIFO_CNT_W-1:0]  rd_fifo_cnt,
    output logic                        rd_fifo_empty,
    // burst port to memory
    input  logic                        mem_init_done,
    output logic                        mem_wr_req,
    output logic                        mem_rd_req,
    input  logic                        mem_wr_ack,     // one per beat
    input  logic                        mem_rd_ack,
    output mcb_pkg::mcb_addr_u          mem_addr,
    output logic [`MCB_BURST_W-1:0]     mem_len,
    output logic [`MCB_DATA_W-1:0]      mem_wr_data,
    input  logic [`MCB_DATA_W-1:0]      mem_rd_data
);

    import mcb_pkg::*;

    logic [`MCB_FIFO_CNT_W-1:0] wr_fifo_cnt;
    logic                       wr_fifo_full;
    logic                       wr_pending;
    logic                       rd_pending;
    mcb_addr_u                  wr_cur_addr;
    mcb_addr_u                  rd_cur_addr;
    logic [`MCB_BURST_W-1:0]    wr_burst_len;
    logic [`MCB_BURST_W-1:0]    rd_burst_len;
    logic                       wr_last;
    logic                       rd_last;
    logic                       wr_stage_done;
    logic                       rd_stage_done;
    logic                       burst_start;
    logic                       burst_is_rd;
    logic                       burst_done;

    assign wr_rdy = mem_init_done & ~wr_fifo_full;     // user may push

    mcb_transfer_tracker u_wr_track (
        .clk_sdram(clk_sdram), .rst_n(rst_n),
        .load(wr_load), .load_addr(wr_addr), .load_len(wr_length),
        .stage_done(wr_stage_done), .pending(wr_pending), .cur_addr(wr_cur_addr),
        .burst_len(wr_burst_len), .last_burst(wr_last)
    );

    mcb_transfer_tracker u_rd_track (
        .clk_sdram(clk_sdram), .rst_n(rst_n),
        .load(rd_load), .load_addr(rd_addr), .load_len(rd_length),
        .stage_done(rd_stage_done), .pending(rd_pending), .cur_addr(rd_cur_addr),
        .burst_len(rd_burst_len), .last_burst(rd_last)
    );

    mcb_scheduler u_sched (
        .clk_sdram(clk_sdram), .rst_n(rst_n), .mem_init_done(mem_init_done),
        .wr_pending(wr_pending), .rd_pending(rd_pending),
        .wr_burst_len(wr_burst_len), .rd_burst_len(rd_burst_len),
        .wr_last(wr_last), .rd_last(rd_last),
        .wr_fifo_cnt(wr_fifo_cnt), .rd_fifo_cnt(rd_fifo_cnt),
        .burst_done(burst_done), .burst_start(burst_start), .burst_is_rd(burst_is_rd),
        .wr_stage_done(wr_stage_done), .rd_stage_done(rd_stage_done),
        .wr_done(wr_done), .rd_done(rd_done)
    );

    mcb_burst_engine u_engine (
        .clk_sdram(clk_sdram), .rst_n(rst_n),
        .burst_start(burst_start), .burst_is_rd(burst_is_rd),
        .wr_addr(wr_cur_addr), .rd_addr(rd_cur_addr),
        .wr_len(wr_burst_len), .rd_len(rd_burst_len),
        .mem_wr_ack(mem_wr_ack), .mem_rd_ack(mem_rd_ack),
        .mem_wr_req(mem_wr_req), .mem_rd_req(mem_rd_req),
        .mem_addr(mem_addr), .mem_len(mem_len), .burst_done(burst_done)
    );

    // user pushes, memory pops on each write ack
    mcb_fifo u_wr_fifo (
        .clk_sdram(clk_sdram), .rst_n(rst_n),
        .push(wr_req), .push_data(din), .pop(mem_wr_ack), .head(mem_wr_data),
        .count(wr_fifo_cnt), .full(wr_fifo_full), .empty()
    );

    // memory pushes on each read ack, user pops
    mcb_fifo u_rd_fifo (
        .clk_sdram(clk_sdram), .rst_n(rst_n),
        .push(mem_rd_ack), .push_data(mem_rd_data), .pop(rd_req), .head(dout),
        .count(rd_fifo_cnt), .full(), .empty(rd_fifo_empty)
    );

endmodule

/* verif/sdram_mcb_properties.sv */
`timescale 1ns/1ps
`include "mcb_settings.svh"

module sdram_mcb_properties (
    input logic                     clk_sdram,
    input logic                     rst_n,
    input logic                     mem_init_done,
    input logic                     mem_wr_req,
    input logic                     mem_rd_req,
    input logic                     mem_wr_ack,
    input logic                     mem_rd_ack,
    input mcb_pkg::mcb_addr_u       mem_addr,
    input logic [`MCB_BURST_W-1:0]  mem_len,
    input logic                     wr_done,
    input logic                     rd_done
);

    a_req_after_init: assert property (@(posedge clk_sdram) disable iff (!rst_n)
        $rose(mem_wr_req || mem_rd_req) |-> mem_init_done)
        else $error("burst request raised before memory init");
    // a burst of one direction never overlaps request or beats of the other
    a_one_dir: assert property (@(posedge clk_sdram) disable iff (!rst_n)
        !((mem_wr_req || mem_wr_ack) && (mem_rd_req || mem_rd_ack)))
        else $error("write and read bursts overlap on the port");
    a_in_row: assert property (@(posedge clk_sdram) disable iff (!rst_n)
        (mem_wr_req || mem_rd_req) |-> (11'(mem_addr.field.col) + 11'(mem_len) <= 11'd512))
        else $error("burst runs past the row end");
    a_wr_pulse: assert property (@(posedge clk_sdram) disable iff (!rst_n)
        wr_done |=> !wr_done) else $error("wr_done longer than one cycle");
    a_rd_pulse: assert property (@(posedge clk_sdram) disable iff (!rst_n)
        rd_done |=> !rd_done) else $error("rd_done longer than one cycle");

endmodule

bind sdram_mcb_top sdram_mcb_properties u_props (
    .clk_sdram(clk_sdram), .rst_n(rst_n), .mem_init_done(mem_init_done),
    .mem_wr_req(mem_wr_req), .mem_rd_req(mem_rd_req),
    .mem_wr_ack(mem_wr_ack), .mem_rd_ack(mem_rd_ack), .mem_addr(mem_addr),
    .mem_len(mem_len), .wr_done(wr_done), .rd_done(rd_done)
);

/* verif/tb_burst_memory.sv */
`timescale 1ns/1ps
`include "mcb_settings.svh"

module tb_burst_memory (
    input  logic                        clk_sdram,
    input  logic                        rst_n,
    input  logic                        mem_wr_req,
    input  logic                        mem_rd_req,
    input  mcb_pkg::mcb_addr_u          mem_addr,
    input  logic [`MCB_BURST_W-1:0]     mem_len,
    input  logic [`MCB_DATA_W-1:0]      mem_wr_data,
    output logic                        mem_init_done,
    output logic                        mem_wr_ack,
    output logic                        mem_rd_ack,
    output logic [`MCB_DATA_W-1:0]      mem_rd_data
);

    logic [`MCB_DATA_W-1:0] mem [0:65535];      // low 16 address bits only
    int                     seed = 32'h390c;    // ack gap stream
    int                     init_cnt;
    int                     left;               // beats still to ack
    logic                   busy;
    logic                   is_rd;
    logic [15:0]            ptr;                // next beat address
    logic [15:0]            wptr;               // next write store address

    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem[a] = 16'(a) ^ 16'hc3a5;         // background pattern
        end
    end

    always @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            init_cnt      = 0;
            busy          = 1'b0;
            mem_init_done <= 1'b0;
            mem_wr_ack    <= 1'b0;
            mem_rd_ack    <= 1'b0;
            mem_rd_data   <= '0;
        end else begin
            if (init_cnt < 20) init_cnt++;      // init finishes 20 cycles after reset
            else mem_init_done <= 1'b1;
            if (mem_wr_ack) begin
                mem[wptr] = mem_wr_data;        // fifo head seen with the ack
                wptr++;
            end
            mem_wr_ack <= 1'b0;
            mem_rd_ack <= 1'b0;
            if (!busy) begin
                // req is still high for one edge after a single-beat burst
                if ((mem_wr_req || mem_rd_req) && !mem_wr_ack && !mem_rd_ack) begin
                    busy  = 1'b1;
                    is_rd = mem_rd_req;
                    left  = int'(mem_len);
                    ptr   = mem_addr.linear[15:0];
                    wptr  = mem_addr.linear[15:0];
                end
            end else if (($random(seed) & 3) != 0) begin    // gap about 1 in 4
                if (is_rd) begin
                    mem_rd_ack  <= 1'b1;
                    mem_rd_data <= mem[ptr];
                end else begin
                    mem_wr_ack <= 1'b1;
                end
                ptr++;
                left--;
                if (left == 0) busy = 1'b0;
            end
        end
    end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_sdram,
    output logic rst_n
);

    initial clk_sdram = 1'b0;
    always #4 clk_sdram = ~clk_sdram;           // 8 ns period

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk_sdram);       // reset held 16 cycles
        rst_n <= 1'b1;
    end

endmodule

/* verif/tb_sdram_mcb.sv */
`timescale 1ns/1ps
`include "mcb_settings.svh"

module tb_sdram_mcb;

    import mcb_pkg::*;

    localparam int N_TESTS = 9;
    localparam int OP_RESET = 0, OP_WR = 1, OP_RD = 2, OP_WR2 = 3;
    localparam int OP_FULL = 4, OP_RDLATE = 5, OP_BOTH = 6;

    // test table, addr2 is the ignored reload or the overlapping read
    string t_name   [N_TESTS] = '{"reset_state", "wr_one_row", "rd_one_row", "wr_row_cross",
                                  "rd_row_cross", "wr_second_load", "fifo_full_push",
                                  "rd_late_drain", "wr_rd_overlap"};
    int    t_op     [N_TESTS] = '{0, 1, 2, 1, 2, 3, 4, 5, 6};
    int    t_addr   [N_TESTS] = '{'h1000, 'h100, 'h100, 'h11f4, 'h11f4,
                                  'h3000, 'h6000, 'h6000, 'h8000};
    int    t_addr2  [N_TESTS] = '{0, 0, 0, 0, 0, 'h5000, 0, 0, 'h6000};
    int    t_len    [N_TESTS] = '{64, 64, 64, 600, 600, 300, 1024, 1100, 1024};
    int    t_seed   [N_TESTS] = '{0, 1, 0, 2, 0, 3, 4, 0, 5};
    int    t_bursts [N_TESTS] = '{1, 1, 1, 3, 3, 1, 2, 3, 2};   // 12+512+76 for col 500

    logic clk_sdram, rst_n;
    logic wr_load = 0, wr_req = 0, rd_load = 0, rd_req = 0;
    mcb_addr_u wr_addr = '0, rd_addr = '0, mem_addr;
    logic [`MCB_LEN_W-1:0] wr_length = '0, rd_length = '0;
    logic [`MCB_DATA_W-1:0] din = '0, dout, mem_wr_data, mem_rd_data;
    logic wr_done, wr_rdy, rd_done, rd_fifo_empty, mem_init_done;
    logic mem_wr_req, mem_rd_req, mem_wr_ack, mem_rd_ack, wr_req_q = 0, rd_req_q = 0;
    logic [`MCB_FIFO_CNT_W-1:0] rd_fifo_cnt;
    logic [`MCB_BURST_W-1:0] mem_len;
    logic [15:0] shadow [0:65535];                  // expected memory contents
    bit log_rd[$];                                  // bursts seen on the port
    int log_addr[$], log_len[$];
    int wr_done_cnt = 0, rd_done_cnt = 0, max_rd_cnt = 0;
    int errors = 0, failed = 0, test_errors = 0;

    tb_clock_gen u_clk (.clk_sdram(clk_sdram), .rst_n(rst_n));

    sdram_mcb_top uut (.*);

    tb_burst_memory u_mem (.*);

    always @(posedge clk_sdram) begin
        if (mem_wr_req && !wr_req_q) begin          // new write burst
            log_rd.push_back(1'b0);
            log_addr.push_back(int'(mem_addr.linear));
            log_len.push_back(int'(mem_len));
        end
        if (mem_rd_req && !rd_req_q) begin
            log_rd.push_back(1'b1);
            log_addr.push_back(int'(mem_addr.linear));
            log_len.push_back(int'(mem_len));
        end
        wr_req_q <= mem_wr_req;
        rd_req_q <= mem_rd_req;
        if (wr_done) wr_done_cnt <= wr_done_cnt + 1;
        if (rd_done) rd_done_cnt <= rd_done_cnt + 1;
        if (int'(rd_fifo_cnt) > max_rd_cnt) max_rd_cnt <= int'(rd_fifo_cnt);
    end

    function automatic logic [15:0] data_word(input int seed, input int i);
        return 16'((seed * 4099) ^ (i * 37) ^ (i >> 4));
    endfunction

    task automatic check_value(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Fail %s: expected %0h, actual %0h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic report_error(input string name, input string what);
        $display("Error in %s: %s", name, what);
        test_errors++;
    endtask

    // each burst stops at the row end or the end of the transfer
    task automatic check_bursts(input string name, input bit is_rd, input int addr,
                                input int len, input int nexp);
        int a, rem, n, seen;
        a = addr;
        rem = len;
        seen = 0;
        for (int k = 0; k < log_rd.size(); k++) begin
            if (log_rd[k] == is_rd) begin
                n = (rem < 512 - (a % 512)) ? rem : 512 - (a % 512);
                check_value({name, " burst addr"}, a, log_addr[k]);
                check_value({name, " burst len"}, n, log_len[k]);
                a += n;
                rem -= n;
                seen++;
            end
        end
        check_value({name, " burst count"}, nexp, seen);
    endtask

    task automatic check_memory(input string name);
        int bad;
        bad = 0;
        for (int a = 0; a < 65536; a++) begin
            if (u_mem.mem[a] !== shadow[a]) begin
                if (bad == 0) check_value({name, " memory word"}, int'(shadow[a]),
                                          int'(u_mem.mem[a]));
                bad++;
            end
        end
        if (bad > 1) report_error(name, $sformatf("%0d memory words differ", bad));
    endtask

    task automatic write_xfer(input int t);
        int start;
        start = wr_done_cnt;
        @(posedge clk_sdram);
        if (t_op[t] == OP_FULL) check_value({t_name[t], " wr_rdy empty"}, 1, int'(wr_rdy));
        wr_addr.linear <= 24'(t_addr[t]);
        wr_length      <= 24'(t_len[t]);
        if (t_op[t] != OP_FULL) wr_load <= 1'b1;     // full test pushes before loading
        for (int i = 0; i < t_len[t]; i++) begin
            wr_req <= 1'b1;
            din    <= data_word(t_seed[t], i);
            shadow[16'(t_addr[t] + i)] = data_word(t_seed[t], i);
            if (t_op[t] == OP_WR2 && i == t_len[t] / 2) wr_load <= 1'b0;
            if (t_op[t] == OP_WR2 && i == t_len[t] / 2 + 2) begin
                wr_addr.linear <= 24'(t_addr2[t]); // second rise while pending
                wr_load        <= 1'b1;
            end
            @(posedge clk_sdram);
        end
        wr_req <= 1'b0;
        if (t_op[t] == OP_FULL) begin
            @(posedge clk_sdram);
            check_value({t_name[t], " wr_rdy full"}, 0, int'(wr_rdy));
            wr_load <= 1'b1;
        end
        while (wr_done_cnt == start) @(posedge clk_sdram);
        repeat (20) @(posedge clk_sdram);           // room for a stray second pulse
        wr_load <= 1'b0;
        check_value({t_name[t], " wr_done pulses"}, 1, wr_done_cnt - start);
        check_bursts(t_name[t], 1'b0, t_addr[t], t_len[t], t_bursts[t]);
        check_memory(t_name[t]);
    endtask

    task automatic read_xfer(input string name, input int addr, input int len,
                             input bit late, input int nexp);
        int got, start;
        got = 0;
        start = rd_done_cnt;
        @(posedge clk_sdram);
        rd_addr.linear <= 24'(addr);
        rd_length      <= 24'(len);
        rd_load        <= 1'b1;
        rd_req         <= !late;
        if (late) begin
            while (int'(rd_fifo_cnt) < 512) @(posedge clk_sdram);
            repeat (200) @(posedge clk_sdram);      // next 512 burst has no room
            check_value({name, " stalled count"}, 512, int'(rd_fifo_cnt));
            if (mem_rd_req) report_error(name, "read burst issued without fifo room");
            rd_req <= 1'b1;
        end
        while (got < len) begin
            @(posedge clk_sdram);
            if (rd_req && !rd_fifo_empty) begin     // pop lands on this edge
                check_value({name, " data"}, int'(shadow[16'(addr + got)]), int'(dout));
                got++;
                if (got == len) rd_req <= 1'b0;
            end
        end
        while (rd_done_cnt == start) @(posedge clk_sdram);
        repeat (20) @(posedge clk_sdram);
        rd_load <= 1'b0;
        check_value({name, " rd_done pulses"}, 1, rd_done_cnt - start);
        check_bursts(name, 1'b1, addr, len, nexp);
    endtask

    task automatic reset_checks(input int t);
        while (rst_n !== 1'b1) @(posedge clk_sdram);
        @(posedge clk_sdram);
        check_value({t_name[t], " wr_done"}, 0, int'(wr_done));
        check_value({t_name[t], " rd_done"}, 0, int'(rd_done));
        check_value({t_name[t], " mem_wr_req"}, 0, int'(mem_wr_req));
        check_value({t_name[t], " mem_rd_req"}, 0, int'(mem_rd_req));
        check_value({t_name[t], " rd_fifo_empty"}, 1, int'(rd_fifo_empty));
        check_value({t_name[t], " rd_fifo_cnt"}, 0, int'(rd_fifo_cnt));
        check_value({t_name[t], " wr_rdy before init"}, 0, int'(wr_rdy));
        // read of the background loaded before init, its burst waits for init
        read_xfer(t_name[t], t_addr[t], t_len[t], 1'b0, t_bursts[t]);
        check_value({t_name[t], " wr_rdy after init"}, 1, int'(wr_rdy));
    endtask

    initial begin
        for (int a = 0; a < 65536; a++) shadow[a] = 16'(a) ^ 16'hc3a5;
        for (int t = 0; t < N_TESTS; t++) begin
            test_errors = 0;
            log_rd.delete();
            log_addr.delete();
            log_len.delete();
            case (t_op[t])
                OP_RESET: reset_checks(t);
                OP_WR, OP_WR2, OP_FULL: write_xfer(t);
                OP_RD: read_xfer(t_name[t], t_addr[t], t_len[t], 1'b0, t_bursts[t]);
                OP_RDLATE: begin
                    read_xfer(t_name[t], t_addr[t], t_len[t], 1'b1, t_bursts[t]);
                    if (max_rd_cnt > `MCB_FIFO_DEPTH - 1)
                        report_error(t_name[t], "read fifo count went above 1023");
                end
                default: begin                      // write and read loaded together
                    fork
                        write_xfer(t);
                        read_xfer(t_name[t], t_addr2[t], t_len[t], 1'b0, t_bursts[t]);
                    join
                    for (int k = 1; k < log_rd.size(); k++) begin
                        if (log_rd[k] == log_rd[k-1])
                            report_error(t_name[t], "bursts did not alternate direction");
                    end
                end
            endcase
            if (test_errors == 0) $display("test %s: ok", t_name[t]);
            else $display("test %s: %0d errors", t_name[t], test_errors);
            errors += test_errors;
            if (test_errors != 0) failed++;
        end
        $display("tests %0d, failed %0d, errors %0d", N_TESTS, failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // 40 cycles per word over the whole table plus setup
    initial begin
        int limit;
        limit = 2000;
        foreach (t_len[t]) limit += 40 * t_len[t];
        repeat (limit) @(posedge clk_sdram);
        $display("watchdog expired after %0d cycles, run did not finish", limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
